//--- common/dma_pkg.sv
package dma_pkg;

    // ==================================================
    // Widths and types
    // ==================================================
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int BEAT_BYTES = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [31:0]       len_t;
    typedef logic [7:0]        burst_t;

    localparam int REG_ADDR_W = 5;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ==================================================
    // Register map
    // ==================================================
    localparam reg_addr_t REG_SRC   = 5'h00;
    localparam reg_addr_t REG_DST   = 5'h08;
    localparam reg_addr_t REG_LEN   = 5'h10;
    localparam reg_addr_t REG_BURST = 5'h18;
    localparam reg_addr_t REG_CTRL  = 5'h1C;

    // Control register bits
    localparam int CTRL_START = 0;
    localparam int CTRL_DONE  = 1;
    localparam int CTRL_BUSY  = 2;

    // Beat FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_IDX_W = $clog2(FIFO_DEPTH);
    // Extra bit so a full FIFO has its own count value
    localparam int FIFO_PTR_W = FIFO_IDX_W + 1;

    typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_DATA} read_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_POP, WR_SEND, WR_WAIT} write_state_e;

    // Beats in the next burst, burst of 0 counts as 1
    function automatic burst_t burst_beats(len_t rem, burst_t burst);
        len_t   left;
        burst_t eff;
        left = rem / BEAT_BYTES + len_t'(rem % BEAT_BYTES != 0);
        eff  = (burst == '0) ? burst_t'(1) : burst;
        return (left < len_t'(eff)) ? burst_t'(left) : eff;
    endfunction

    // Bytes left after one beat, saturates at zero for a partial tail
    function automatic len_t rem_after_beat(len_t rem);
        return (rem > len_t'(BEAT_BYTES)) ? rem - len_t'(BEAT_BYTES) : '0;
    endfunction

endpackage

//--- dma_engine/dma_read_engine.sv
`timescale 1ns/1ps

module dma_read_engine
    import dma_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  addr_t                 src_i,
    input  len_t                  len_i,
    input  burst_t                burst_i,
    input  logic [FIFO_PTR_W-1:0] fifo_count_i,
    input  logic                  gnt_i,
    input  logic                  rvalid_i,
    input  data_t                 rdata_i,
    output logic                  req_o,
    output addr_t                 addr_o,
    output burst_t                beats_o,
    output logic                  push_o,
    output data_t                 push_data_o
);

    read_state_e state_q;
    addr_t       addr_q;
    len_t        rem_q;
    burst_t      burst_q;
    burst_t      cnt_q;
    logic [8:0]  need;

    // Room check covers the whole burst so returned beats never stall
    assign beats_o = burst_beats(rem_q, burst_q);
    assign need    = 9'(fifo_count_i) + 9'(beats_o);
    assign req_o   = (state_q == RD_REQ) && (rem_q != '0) && (need <= 9'(FIFO_DEPTH));
    assign addr_o  = addr_q;

    assign push_o      = (state_q == RD_DATA) && rvalid_i;
    assign push_data_o = rdata_i;

    // ==================================================
    // Read FSM
    // ==================================================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q <= RD_IDLE;
            addr_q  <= '0;
            rem_q   <= '0;
            burst_q <= '0;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (start_i) begin
                        state_q <= RD_REQ;
                        addr_q  <= src_i;
                        rem_q   <= len_i;
                        // A burst longer than the FIFO could never fit
                        if (burst_i > burst_t'(FIFO_DEPTH)) begin
                            burst_q <= burst_t'(FIFO_DEPTH);
                        end else begin
                            burst_q <= burst_i;
                        end
                    end
                end
                RD_REQ: begin
                    if (rem_q == '0) begin
                        state_q <= RD_IDLE;
                    end else if (gnt_i) begin
                        state_q <= RD_DATA;
                        cnt_q   <= beats_o;
                    end
                end
                RD_DATA: begin
                    if (rvalid_i) begin
                        addr_q <= addr_q + addr_t'(BEAT_BYTES);
                        rem_q  <= rem_after_beat(rem_q);
                        cnt_q  <= cnt_q - 1'b1;
                        // Last beat of the burst
                        if (cnt_q == 8'd1) begin
                            state_q <= RD_REQ;
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

endmodule

//--- dma_engine/dma_write_engine.sv
`timescale 1ns/1ps

module dma_write_engine
    import dma_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   start_i,
    input  addr_t  dst_i,
    input  len_t   len_i,
    input  burst_t burst_i,
    input  logic   fifo_empty_i,
    input  data_t  fifo_data_i,
    input  logic   gnt_i,
    input  logic   bdone_i,
    output logic   pop_o,
    output logic   req_o,
    output addr_t  addr_o,
    output data_t  wdata_o,
    output logic   last_o,
    output logic   xfer_done_o
);

    write_state_e state_q;
    addr_t        addr_q;
    len_t         rem_q;
    burst_t       burst_q;
    // Beats left in the current burst, 0 between bursts
    burst_t       cnt_q;

    assign pop_o       = (state_q == WR_POP) && (rem_q != '0) && !fifo_empty_i;
    assign req_o       = (state_q == WR_SEND);
    assign addr_o      = addr_q;
    assign wdata_o     = fifo_data_i;
    assign last_o      = (state_q == WR_SEND) && (cnt_q == 8'd1);
    assign xfer_done_o = (state_q == WR_POP) && (rem_q == '0);

    // ==================================================
    // Write FSM
    // ==================================================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q <= WR_IDLE;
            addr_q  <= '0;
            rem_q   <= '0;
            burst_q <= '0;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (start_i) begin
                        state_q <= WR_POP;
                        addr_q  <= dst_i;
                        rem_q   <= len_i;
                        burst_q <= burst_i;
                        cnt_q   <= '0;
                    end
                end
                WR_POP: begin
                    if (rem_q == '0) begin
                        state_q <= WR_IDLE;
                    end else if (!fifo_empty_i) begin
                        state_q <= WR_SEND;
                        // First beat of a burst sizes it
                        if (cnt_q == '0) begin
                            cnt_q <= burst_beats(rem_q, burst_q);
                        end
                    end
                end
                WR_SEND: begin
                    if (gnt_i) begin
                        addr_q <= addr_q + addr_t'(BEAT_BYTES);
                        rem_q  <= rem_after_beat(rem_q);
                        cnt_q  <= cnt_q - 1'b1;
                        state_q <= (cnt_q == 8'd1) ? WR_WAIT : WR_POP;
                    end
                end
                WR_WAIT: begin
                    if (bdone_i) begin
                        state_q <= WR_POP;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    a_last_with_req: assert property (@(posedge clk_i) disable iff (!rst_i)
        last_o |-> req_o)
        else $error("last_o without a write request");

    // FIFO output must hold the beat while the bus is busy
    a_wdata_held: assert property (@(posedge clk_i) disable iff (!rst_i)
        req_o && !gnt_i |=> req_o && $stable(wdata_o) && $stable(addr_o))
        else $error("write beat changed before grant");

endmodule

//--- filelist.f
common/dma_pkg.sv
hw/dma_regs.sv
hw/dma_fifo.sv
dma_engine/dma_read_engine.sv
dma_engine/dma_write_engine.sv
hw/dma_bus_arbiter.sv
hw/dma_top.sv
tests/tb_dma.sv

//--- hw/dma_bus_arbiter.sv
`timescale 1ns/1ps

module dma_bus_arbiter
    import dma_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   rd_req_i,
    input  addr_t  rd_addr_i,
    input  burst_t rd_beats_i,
    input  logic   wr_req_i,
    input  addr_t  wr_addr_i,
    input  data_t  wr_wdata_i,
    input  logic   wr_last_i,
    input  logic   mem_gnt_i,
    output logic   rd_gnt_o,
    output logic   wr_gnt_o,
    output logic   mem_req_o,
    output logic   mem_we_o,
    output addr_t  mem_addr_o,
    output data_t  mem_wdata_o,
    output burst_t mem_beats_o,
    output logic   mem_last_o
);

    // Selection index, 0 is read and 1 is write
    logic prio_q;
    logic lock_q;
    logic sel_q;
    logic sel;

    always_comb begin
        if (lock_q) begin
            sel = sel_q;
        end else if (rd_req_i && wr_req_i) begin
            sel = prio_q;
        end else begin
            sel = wr_req_i;
        end
    end

    assign mem_req_o   = sel ? wr_req_i : rd_req_i;
    assign mem_we_o    = sel;
    assign mem_addr_o  = sel ? wr_addr_i : rd_addr_i;
    assign mem_wdata_o = sel ? wr_wdata_i : '0;
    // Writes go one beat per request
    assign mem_beats_o = sel ? burst_t'(1) : rd_beats_i;
    assign mem_last_o  = sel && wr_last_i;

    assign rd_gnt_o = mem_gnt_i && !sel;
    assign wr_gnt_o = mem_gnt_i && sel;

    // Round robin pointer and lock on a waiting request
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            prio_q <= 1'b0;
            lock_q <= 1'b0;
            sel_q  <= 1'b0;
        end else if (mem_gnt_i) begin
            prio_q <= !sel;
            lock_q <= 1'b0;
        end else if (mem_req_o) begin
            lock_q <= 1'b1;
            sel_q  <= sel;
        end
    end

    a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(rd_gnt_o && wr_gnt_o))
        else $error("both engines granted");

    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o))
        else $error("bus request changed before grant");

endmodule

//--- hw/dma_fifo.sv
`timescale 1ns/1ps

module dma_fifo
    import dma_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  push_i,
    input  data_t                 data_i,
    input  logic                  pop_i,
    output data_t                 data_o,
    output logic                  empty_o,
    output logic [FIFO_PTR_W-1:0] count_o
);

    data_t                 mem_q [FIFO_DEPTH];
    logic [FIFO_IDX_W-1:0] wr_ptr_q;
    logic [FIFO_IDX_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W-1:0] count_q;
    logic                  full;

    assign full    = (count_q == FIFO_PTR_W'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign count_o = count_q;

    // Storage and registered read port, output holds until the next pop
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
        if (pop_i) begin
            data_o <= mem_q[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // Read engine reserves room before each burst
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_i)
        push_i |-> !full)
        else $error("push into a full FIFO");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_i)
        pop_i |-> !empty_o)
        else $error("pop from an empty FIFO");

endmodule

//--- hw/dma_regs.sv
`timescale 1ns/1ps

module dma_regs
    import dma_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      reg_en_i,
    input  logic      reg_we_i,
    input  reg_addr_t reg_addr_i,
    input  data_t     reg_wdata_i,
    input  logic      xfer_done_i,
    output data_t     reg_rdata_o,
    output logic      start_o,
    output addr_t     src_o,
    output addr_t     dst_o,
    output len_t      len_o,
    output burst_t    burst_o,
    output logic      done_o
);

    addr_t  src_q;
    addr_t  dst_q;
    len_t   len_q;
    burst_t burst_q;
    logic   start_q;
    logic   done_q;
    logic   busy_q;
    logic   wr_en;
    logic   start_wr;
    data_t  ctrl_val;
    data_t  rd_mux;

    assign wr_en    = reg_en_i && reg_we_i;
    // Start is only taken while idle
    assign start_wr = wr_en && (reg_addr_i == REG_CTRL) && reg_wdata_i[CTRL_START] && !busy_q;

    always_comb begin
        ctrl_val             = '0;
        ctrl_val[CTRL_START] = start_q;
        ctrl_val[CTRL_DONE]  = done_q;
        ctrl_val[CTRL_BUSY]  = busy_q;
    end

    always_comb begin
        case (reg_addr_i)
            REG_SRC:   rd_mux = data_t'(src_q);
            REG_DST:   rd_mux = data_t'(dst_q);
            REG_LEN:   rd_mux = data_t'(len_q);
            REG_BURST: rd_mux = data_t'(burst_q);
            REG_CTRL:  rd_mux = ctrl_val;
            default:   rd_mux = '0;
        endcase
    end

    // ==================================================
    // Configuration and status
    // ==================================================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            src_q   <= '0;
            dst_q   <= '0;
            len_q   <= '0;
            burst_q <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
            busy_q  <= 1'b0;
            start_o <= 1'b0;
        end else begin
            // Transfer settings are frozen while busy
            if (wr_en && !busy_q) begin
                case (reg_addr_i)
                    REG_SRC:   src_q   <= reg_wdata_i[ADDR_W-1:0];
                    REG_DST:   dst_q   <= reg_wdata_i[ADDR_W-1:0];
                    REG_LEN:   len_q   <= reg_wdata_i[31:0];
                    REG_BURST: burst_q <= reg_wdata_i[7:0];
                    default: ;
                endcase
            end
            start_o <= start_wr;
            if (start_wr) begin
                start_q <= 1'b1;
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
            end else if (xfer_done_i) begin
                start_q <= 1'b0;
                busy_q  <= 1'b0;
                done_q  <= 1'b1;
            end
        end
    end

    // Read data one cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (reg_en_i && !reg_we_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

    assign src_o   = src_q;
    assign dst_o   = dst_q;
    assign len_o   = len_q;
    assign burst_o = burst_q;
    assign done_o  = done_q;

    // A start pulse only comes out of an idle register file
    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        start_o |-> busy_q && !$past(busy_q))
        else $error("start_o fired while busy");

endmodule

//--- hw/dma_top.sv
`timescale 1ns/1ps

module dma_top
    import dma_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      reg_en_i,
    input  logic      reg_we_i,
    input  reg_addr_t reg_addr_i,
    input  data_t     reg_wdata_i,
    output data_t     reg_rdata_o,
    input  logic      mem_gnt_i,
    input  logic      mem_rvalid_i,
    input  data_t     mem_rdata_i,
    input  logic      mem_bdone_i,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output data_t     mem_wdata_o,
    output burst_t    mem_beats_o,
    output logic      mem_last_o,
    output logic      done_o
);

    logic                  start;
    addr_t                 src;
    addr_t                 dst;
    len_t                  len;
    burst_t                burst;
    logic                  xfer_done;
    logic                  push;
    data_t                 push_data;
    logic                  pop;
    data_t                 pop_data;
    logic                  fifo_empty;
    logic [FIFO_PTR_W-1:0] fifo_count;
    logic                  rd_req;
    logic                  rd_gnt;
    addr_t                 rd_addr;
    burst_t                rd_beats;
    logic                  wr_req;
    logic                  wr_gnt;
    addr_t                 wr_addr;
    data_t                 wr_wdata;
    logic                  wr_last;

    dma_regs u_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .reg_en_i    (reg_en_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .xfer_done_i (xfer_done),
        .reg_rdata_o (reg_rdata_o),
        .start_o     (start),
        .src_o       (src),
        .dst_o       (dst),
        .len_o       (len),
        .burst_o     (burst),
        .done_o      (done_o)
    );

    dma_fifo u_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (push),
        .data_i  (push_data),
        .pop_i   (pop),
        .data_o  (pop_data),
        .empty_o (fifo_empty),
        .count_o (fifo_count)
    );

    // Read data returns only to the read engine
    dma_read_engine u_read (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (start),
        .src_i        (src),
        .len_i        (len),
        .burst_i      (burst),
        .fifo_count_i (fifo_count),
        .gnt_i        (rd_gnt),
        .rvalid_i     (mem_rvalid_i),
        .rdata_i      (mem_rdata_i),
        .req_o        (rd_req),
        .addr_o       (rd_addr),
        .beats_o      (rd_beats),
        .push_o       (push),
        .push_data_o  (push_data)
    );

    dma_write_engine u_write (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (start),
        .dst_i        (dst),
        .len_i        (len),
        .burst_i      (burst),
        .fifo_empty_i (fifo_empty),
        .fifo_data_i  (pop_data),
        .gnt_i        (wr_gnt),
        .bdone_i      (mem_bdone_i),
        .pop_o        (pop),
        .req_o        (wr_req),
        .addr_o       (wr_addr),
        .wdata_o      (wr_wdata),
        .last_o       (wr_last),
        .xfer_done_o  (xfer_done)
    );

    dma_bus_arbiter u_arb (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rd_req_i    (rd_req),
        .rd_addr_i   (rd_addr),
        .rd_beats_i  (rd_beats),
        .wr_req_i    (wr_req),
        .wr_addr_i   (wr_addr),
        .wr_wdata_i  (wr_wdata),
        .wr_last_i   (wr_last),
        .mem_gnt_i   (mem_gnt_i),
        .rd_gnt_o    (rd_gnt),
        .wr_gnt_o    (wr_gnt),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_beats_o (mem_beats_o),
        .mem_last_o  (mem_last_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the DMA testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_dma_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma -f filelist.f \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0

//--- tests/dma_patterns.txt
# Columns in hex: source address, destination address, byte count, burst length
# One transfer per line
00001000 00008000 00000040 08
00001100 00008100 00000050 04
00001200 00008200 00000000 04
00002000 00009000 00000100 10
00002400 00009400 00000038 03
00002800 00009800 00000018 00
00003000 0000a000 00000008 01
00003100 0000a100 000000a8 05
00003400 0000a400 00000080 10
00003800 0000a800 00000000 00
00003c00 0000ac00 00000060 07
00004000 0000b000 00000010 08
00004100 0000b100 000000c8 0c
00004400 0000b400 00000030 02
00004800 0000b800 00000078 0f

//--- tests/tb_dma.sv
`timescale 1ns/1ps

module tb_dma
    import dma_pkg::*;
();

    localparam int    CLK_PERIOD   = 40;
    localparam int    DRIVE_DELAY  = 2;
    localparam int    RESET_CYCLES = 4;
    localparam int    MAX_DELAY    = 3;
    localparam int    SEED         = 60193;
    localparam string PATTERN_FILE = "tests/dma_patterns.txt";

    logic      clk_i = 1'b0;
    logic      rst_i;
    logic      reg_en_i;
    logic      reg_we_i;
    reg_addr_t reg_addr_i;
    data_t     reg_wdata_i;
    data_t     reg_rdata_o;
    logic      mem_gnt_i;
    logic      mem_rvalid_i;
    data_t     mem_rdata_i;
    logic      mem_bdone_i;
    logic      mem_req_o;
    logic      mem_we_o;
    addr_t     mem_addr_o;
    data_t     mem_wdata_o;
    burst_t    mem_beats_o;
    logic      mem_last_o;
    logic      done_o;

    // Memory model and reference image
    data_t  mem [addr_t];
    data_t  ref_mem [addr_t];
    addr_t  rd_addr_q [$];
    burst_t rd_beats_q [$];

    addr_t  pat_src [$];
    addr_t  pat_dst [$];
    len_t   pat_len [$];
    burst_t pat_burst [$];

    // Transfer in progress, used to size the expected bursts
    addr_t cur_src   = '0;
    addr_t cur_dst   = '0;
    int    cur_beats = 0;
    int    cur_burst = 1;

    int req_seen  = 0;
    int errors    = 0;
    int checks    = 0;
    int wd_cycles = 0;

    dma_top dma_top_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .reg_en_i     (reg_en_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_bdone_i  (mem_bdone_i),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_beats_o  (mem_beats_o),
        .mem_last_o   (mem_last_o),
        .done_o       (done_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Preload image, inverted address on top of the address
    function automatic data_t preload_word(addr_t a);
        return {~a, a};
    endfunction

    function automatic data_t mem_word(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return preload_word(a);
    endfunction

    function automatic data_t ref_word(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return preload_word(a);
    endfunction

    task automatic check_data(string name, data_t got, data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_beats(string name, burst_t got, burst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Register access, called 2 ns after a rising edge
    task automatic reg_write(reg_addr_t addr, data_t data);
        reg_en_i    = 1'b1;
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(posedge clk_i);
        #DRIVE_DELAY;
        reg_en_i = 1'b0;
        reg_we_i = 1'b0;
    endtask

    task automatic reg_read(reg_addr_t addr, output data_t val);
        reg_en_i   = 1'b1;
        reg_we_i   = 1'b0;
        reg_addr_i = addr;
        @(posedge clk_i);
        #DRIVE_DELAY;
        reg_en_i = 1'b0;
        val      = reg_rdata_o;
    endtask

    task automatic wait_done(int limit, output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < limit) begin
            if (done_o === 1'b1) begin
                ok = 1'b1;
            end else begin
                @(posedge clk_i);
                #DRIVE_DELAY;
                n++;
            end
        end
        if (!ok) begin
            errors++;
            $display("Error: transfer did not finish before timeout");
        end
    endtask

    // ==================================================
    // Shared bus model
    // ==================================================
    initial begin : bus_model
        int     delay;
        int     idx;
        int     exp_beats;
        logic   exp_last;
        logic   we;
        addr_t  addr;
        data_t  wdata;
        burst_t beats;
        logic   last;
        mem_gnt_i   = 1'b0;
        mem_bdone_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (rst_i === 1'b1 && mem_req_o === 1'b1) begin
                // Request fields are held until grant
                we    = mem_we_o;
                addr  = mem_addr_o;
                wdata = mem_wdata_o;
                beats = mem_beats_o;
                last  = mem_last_o;
                req_seen++;
                // Beat position in the transfer gives the burst shape
                if (we) begin
                    idx      = int'((addr - cur_dst) / BEAT_BYTES);
                    exp_last = ((idx + 1) % cur_burst == 0) || (idx + 1 == cur_beats);
                    check_flag("mem_last_o", last, exp_last);
                end else begin
                    idx       = int'((addr - cur_src) / BEAT_BYTES);
                    exp_beats = cur_beats - idx;
                    if (exp_beats > cur_burst) begin
                        exp_beats = cur_burst;
                    end
                    check_beats("mem_beats_o", beats, burst_t'(exp_beats));
                end
                delay = int'($urandom_range(MAX_DELAY, 0));
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                #DRIVE_DELAY mem_gnt_i = 1'b1;
                @(posedge clk_i);
                #DRIVE_DELAY mem_gnt_i = 1'b0;
                if (we) begin
                    mem[addr] = wdata;
                    if (last) begin
                        delay = int'($urandom_range(MAX_DELAY, 0));
                        repeat (delay) @(posedge clk_i);
                        @(posedge clk_i);
                        #DRIVE_DELAY mem_bdone_i = 1'b1;
                        @(posedge clk_i);
                        #DRIVE_DELAY mem_bdone_i = 1'b0;
                    end
                end else begin
                    rd_addr_q.push_back(addr);
                    rd_beats_q.push_back(beats);
                end
            end
        end
    end

    // Pending reads come back in order after a random gap
    initial begin : read_return
        int     delay;
        addr_t  addr;
        burst_t beats;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(posedge clk_i);
            if (rd_addr_q.size() != 0) begin
                addr  = rd_addr_q.pop_front();
                beats = rd_beats_q.pop_front();
                delay = int'($urandom_range(MAX_DELAY, 0));
                repeat (delay) @(posedge clk_i);
                for (int i = 0; i < int'(beats); i++) begin
                    #DRIVE_DELAY;
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = mem_word(addr + addr_t'(i * BEAT_BYTES));
                    @(posedge clk_i);
                end
                #DRIVE_DELAY mem_rvalid_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk_i);
        $display("Error: run did not complete within %0d cycles", wd_cycles);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin : main
        int     fd;
        string  line;
        addr_t  src;
        addr_t  dst;
        len_t   len;
        burst_t burst;
        addr_t  a;
        data_t  val;
        int     beats;
        int     limit;
        int     reqs_before;
        bit     ok;

        void'($urandom(SEED));
        rst_i       = 1'b0;
        reg_en_i    = 1'b0;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;

        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Error: cannot open pattern file %s", PATTERN_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment lines start with a hash
                if (line.getc(0) != "#" &&
                    $sscanf(line, "%h %h %h %h", src, dst, len, burst) == 4) begin
                    pat_src.push_back(src);
                    pat_dst.push_back(dst);
                    pat_len.push_back(len);
                    pat_burst.push_back(burst);
                end
            end
            $fclose(fd);
        end
        if (fd != 0 && pat_src.size() == 0) begin
            errors++;
            $display("Error: pattern file holds no transfers");
        end

        // Time budget for reset, register test and every transfer
        wd_cycles = RESET_CYCLES + 100;
        foreach (pat_len[i]) begin
            wd_cycles += 200 + 20 * int'((pat_len[i] + len_t'(BEAT_BYTES - 1)) / BEAT_BYTES);
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY rst_i = 1'b1;
        check_flag("mem_req_o", mem_req_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);

        // Register readback
        reg_write(REG_SRC, 64'h1234_5678);
        reg_write(REG_DST, 64'h9abc_def0);
        reg_write(REG_LEN, 64'h0000_0400);
        reg_write(REG_BURST, 64'h0c);
        reg_read(REG_SRC, val);
        check_data("reg_src", val, 64'h1234_5678);
        reg_read(REG_DST, val);
        check_data("reg_dst", val, 64'h9abc_def0);
        reg_read(REG_LEN, val);
        check_data("reg_len", val, 64'h0000_0400);
        reg_read(REG_BURST, val);
        check_data("reg_burst", val, 64'h0c);

        for (int i = 0; i < pat_src.size(); i++) begin
            src   = pat_src[i];
            dst   = pat_dst[i];
            len   = pat_len[i];
            burst = pat_burst[i];
            beats = int'((len + len_t'(BEAT_BYTES - 1)) / BEAT_BYTES);
            reg_write(REG_SRC, data_t'(src));
            reg_write(REG_DST, data_t'(dst));
            reg_write(REG_LEN, data_t'(len));
            reg_write(REG_BURST, data_t'(burst));
            cur_src     = src;
            cur_dst     = dst;
            cur_beats   = beats;
            cur_burst   = (burst == '0) ? 1 : int'(burst);
            reqs_before = req_seen;
            reg_write(REG_CTRL, data_t'(1) << CTRL_START);
            check_flag("done_o", done_o, 1'b0);
            if (beats != 0) begin
                // Second start lands while busy
                reg_write(REG_CTRL, data_t'(1) << CTRL_START);
                reg_read(REG_CTRL, val);
                check_flag("ctrl_busy", val[CTRL_BUSY], 1'b1);
                check_flag("ctrl_done", val[CTRL_DONE], 1'b0);
                limit = 200 + 20 * beats;
            end else begin
                limit = 3;
            end
            wait_done(limit, ok);
            if (!ok) begin
                break;
            end
            reg_read(REG_CTRL, val);
            check_data("ctrl", val, data_t'(1) << CTRL_DONE);
            if (beats == 0) begin
                check_data("mem_req count", data_t'(req_seen - reqs_before), '0);
            end
            for (int b = 0; b < beats; b++) begin
                ref_mem[dst + addr_t'(b * BEAT_BYTES)] = ref_word(src + addr_t'(b * BEAT_BYTES));
            end
            // One word past the end must be untouched
            for (int b = 0; b <= beats; b++) begin
                a = dst + addr_t'(b * BEAT_BYTES);
                check_data($sformatf("mem[%h]", a), mem_word(a), ref_word(a));
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
